// File: logic/xphy_pkg.sv
//////////////////////////////////////////////////////////////
// shared XGMII character codes, bus widths and status sizes
// for the clk156 side of the 10G PHY interface; referenced
// by scoped name from every block and the checker
//////////////////////////////////////////////////////////////
package xphy_pkg;

   // XGMII bus geometry, one control bit per byte lane
   localparam int XGMII_DATA_W = 64;
   localparam int XGMII_CTRL_W = 8;
   localparam int XGMII_LANES  = 8;
   localparam int XGMII_LANE_W = XGMII_DATA_W / XGMII_LANES;

   // control characters, meaningful only with the lane control bit set
   localparam logic [7:0] XGMII_IDLE  = 8'h07;
   // start is only legal in lane 0
   localparam logic [7:0] XGMII_START = 8'hFB;
   localparam logic [7:0] XGMII_TERM  = 8'hFD;
   localparam logic [7:0] XGMII_ERROR = 8'hFE;

   // link status counters saturate at all ones
   localparam int CNT_W = 16;

   // flops between the transceiver status and each core reset
   localparam int RESET_SYNC_STAGES = 2;

endpackage

// File: logic/xphy_reset_sync.sv
//////////////////////////////////////////////////////////////
// builds the tx and rx core resets from transceiver status
// a direction stays in reset until its reset done is high,
// tx_fault is low and signal_detect is high
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xphy_reset_sync
(
   input  logic clk156,
   input  logic reset,
   input  logic tx_resetdone,
   input  logic rx_resetdone,
   input  logic tx_fault,
   input  logic signal_detect,
   output logic core_reset_tx,
   output logic core_reset_rx,
   output logic resetdone
);

   // one shift chain per direction, msb is the core reset
   logic [xphy_pkg::RESET_SYNC_STAGES-1:0] tx_sync;
   logic [xphy_pkg::RESET_SYNC_STAGES-1:0] rx_sync;
   logic                                   line_bad;
   logic                                   tx_hold;
   logic                                   rx_hold;

   // fault or loss of signal holds both directions
   assign line_bad = tx_fault || !signal_detect;
   assign tx_hold  = !tx_resetdone || line_bad;
   assign rx_hold  = !rx_resetdone || line_bad;

   // status inputs are asynchronous to clk156, so the hold
   // condition is sampled through the chain before use
   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         // global reset forces both directions into reset at once
         tx_sync <= '1;
         rx_sync <= '1;
      end
      else
      begin
         tx_sync <= {tx_sync[xphy_pkg::RESET_SYNC_STAGES-2:0], tx_hold};
         rx_sync <= {rx_sync[xphy_pkg::RESET_SYNC_STAGES-2:0], rx_hold};
      end
   end

   assign core_reset_tx = tx_sync[xphy_pkg::RESET_SYNC_STAGES-1];
   assign core_reset_rx = rx_sync[xphy_pkg::RESET_SYNC_STAGES-1];

   // plain combinational status, not synchronized
   assign resetdone = tx_resetdone && rx_resetdone;

endmodule

// File: logic/xgmii_tx_stage.sv
//////////////////////////////////////////////////////////////
// transmit register stage from the MAC toward the transceiver
// puts out idle words while the tx core reset is high and
// pulses tx_sof when a start word is registered
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xgmii_tx_stage
(
   input  logic                              clk156,
   input  logic                              reset,
   input  logic                              core_reset_tx,
   input  logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_txd,
   input  logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_txc,
   output logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_txd_int,
   output logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_txc_int,
   output logic                              tx_sof
);

   logic sof_hit;

   // start is only recognized in lane 0 with its control bit set
   assign sof_hit = xgmii_txc[0] &&
                    (xgmii_txd[xphy_pkg::XGMII_LANE_W-1:0] == xphy_pkg::XGMII_START);

   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         // idle on every lane, all lanes marked as control
         xgmii_txd_int <= {xphy_pkg::XGMII_LANES{xphy_pkg::XGMII_IDLE}};
         xgmii_txc_int <= '1;
         tx_sof        <= 1'b0;
      end
      else if (core_reset_tx)
      begin
         // core held in reset, keep the line idle and drop the word
         xgmii_txd_int <= {xphy_pkg::XGMII_LANES{xphy_pkg::XGMII_IDLE}};
         xgmii_txc_int <= '1;
         tx_sof        <= 1'b0;
      end
      else
      begin
         // one word per cycle, no stall
         xgmii_txd_int <= xgmii_txd;
         xgmii_txc_int <= xgmii_txc;
         // strobe lines up with the registered word
         tx_sof        <= sof_hit;
      end
   end

endmodule

// File: logic/xgmii_rx_stage.sv
//////////////////////////////////////////////////////////////
// receive register stage from the transceiver toward the MAC
// idles the output during rx core reset, flags start words
// in lane 0 and control error characters in any lane
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xgmii_rx_stage
(
   input  logic                              clk156,
   input  logic                              reset,
   input  logic                              core_reset_rx,
   input  logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_rxd_int,
   input  logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_rxc_int,
   output logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_rxd,
   output logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_rxc,
   output logic                              rx_sof,
   output logic                              rx_err
);

   logic sof_hit;
   logic err_hit;

   // start only counts in lane 0
   assign sof_hit = xgmii_rxc_int[0] &&
                    (xgmii_rxd_int[xphy_pkg::XGMII_LANE_W-1:0] == xphy_pkg::XGMII_START);

   // scan every lane for a control error character
   always_comb
   begin
      err_hit = 1'b0;
      for (int i = 0; i < xphy_pkg::XGMII_LANES; i++)
      begin
         // a data byte of FE is payload, not an error
         if (xgmii_rxc_int[i] &&
             (xgmii_rxd_int[i*xphy_pkg::XGMII_LANE_W +: xphy_pkg::XGMII_LANE_W] ==
              xphy_pkg::XGMII_ERROR))
            err_hit = 1'b1;
      end
   end

   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         // idle toward the MAC, strobes quiet
         xgmii_rxd <= {xphy_pkg::XGMII_LANES{xphy_pkg::XGMII_IDLE}};
         xgmii_rxc <= '1;
         rx_sof    <= 1'b0;
         rx_err    <= 1'b0;
      end
      else if (core_reset_rx)
      begin
         // rx core held in reset, the received word is dropped
         xgmii_rxd <= {xphy_pkg::XGMII_LANES{xphy_pkg::XGMII_IDLE}};
         xgmii_rxc <= '1;
         rx_sof    <= 1'b0;
         rx_err    <= 1'b0;
      end
      else
      begin
         xgmii_rxd <= xgmii_rxd_int;
         xgmii_rxc <= xgmii_rxc_int;
         // both strobes aligned with the word they describe
         rx_sof    <= sof_hit;
         rx_err    <= err_hit;
      end
   end

endmodule

// File: logic/xphy_link_status.sv
//////////////////////////////////////////////////////////////
// link status for the clk156 domain
// counts tx and rx frame starts and rx error words into
// saturating counters and raises link_up out of core reset
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xphy_link_status
(
   input  logic                       clk156,
   input  logic                       reset,
   input  logic                       core_reset_tx,
   input  logic                       core_reset_rx,
   input  logic                       tx_sof,
   input  logic                       rx_sof,
   input  logic                       rx_err,
   output logic                       link_up,
   output logic [xphy_pkg::CNT_W-1:0] tx_frames,
   output logic [xphy_pkg::CNT_W-1:0] rx_frames,
   output logic [xphy_pkg::CNT_W-1:0] rx_errors
);

   // add one on a strobe, stick at all ones instead of wrapping
   function automatic logic [xphy_pkg::CNT_W-1:0] sat_inc
   (
      input logic [xphy_pkg::CNT_W-1:0] count,
      input logic                       strobe
   );
      logic [xphy_pkg::CNT_W-1:0] next;
      next = count;
      if (strobe && (count != '1))
         next = count + 1'b1;
      return next;
   endfunction

   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         tx_frames <= '0;
         rx_frames <= '0;
         rx_errors <= '0;
         link_up   <= 1'b0;
      end
      else
      begin
         // strobes are already quiet in core reset, so no gating here
         tx_frames <= sat_inc(tx_frames, tx_sof);
         rx_frames <= sat_inc(rx_frames, rx_sof);
         rx_errors <= sat_inc(rx_errors, rx_err);
         // link needs both directions out of reset
         // counters keep their values across a link drop
         link_up   <= !core_reset_tx && !core_reset_rx;
      end
   end

endmodule

// File: logic/xphy_top.sv
//////////////////////////////////////////////////////////////
// top of the clk156 PHY interface, ties the reset chains,
// the tx and rx register stages and the link status together
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xphy_top
(
   input  logic                              clk156,
   input  logic                              reset,
   input  logic                              tx_resetdone,
   input  logic                              rx_resetdone,
   input  logic                              tx_fault,
   input  logic                              signal_detect,
   input  logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_txd,
   input  logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_txc,
   input  logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_rxd_int,
   input  logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_rxc_int,
   output logic                              resetdone,
   output logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_txd_int,
   output logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_txc_int,
   output logic [xphy_pkg::XGMII_DATA_W-1:0] xgmii_rxd,
   output logic [xphy_pkg::XGMII_CTRL_W-1:0] xgmii_rxc,
   output logic                              link_up,
   output logic [xphy_pkg::CNT_W-1:0]        tx_frames,
   output logic [xphy_pkg::CNT_W-1:0]        rx_frames,
   output logic [xphy_pkg::CNT_W-1:0]        rx_errors
);

   // synchronized core resets, one per direction
   logic core_reset_tx;
   logic core_reset_rx;
   // single-cycle strobes from the stages
   logic tx_sof;
   logic rx_sof;
   logic rx_err;

   xphy_reset_sync u_reset_sync
   (
      .clk156        (clk156),
      .reset         (reset),
      .tx_resetdone  (tx_resetdone),
      .rx_resetdone  (rx_resetdone),
      .tx_fault      (tx_fault),
      .signal_detect (signal_detect),
      .core_reset_tx (core_reset_tx),
      .core_reset_rx (core_reset_rx),
      .resetdone     (resetdone)
   );

   xgmii_tx_stage u_tx_stage
   (
      .clk156        (clk156),
      .reset         (reset),
      .core_reset_tx (core_reset_tx),
      .xgmii_txd     (xgmii_txd),
      .xgmii_txc     (xgmii_txc),
      .xgmii_txd_int (xgmii_txd_int),
      .xgmii_txc_int (xgmii_txc_int),
      .tx_sof        (tx_sof)
   );

   xgmii_rx_stage u_rx_stage
   (
      .clk156        (clk156),
      .reset         (reset),
      .core_reset_rx (core_reset_rx),
      .xgmii_rxd_int (xgmii_rxd_int),
      .xgmii_rxc_int (xgmii_rxc_int),
      .xgmii_rxd     (xgmii_rxd),
      .xgmii_rxc     (xgmii_rxc),
      .rx_sof        (rx_sof),
      .rx_err        (rx_err)
   );

   xphy_link_status u_link_status
   (
      .clk156        (clk156),
      .reset         (reset),
      .core_reset_tx (core_reset_tx),
      .core_reset_rx (core_reset_rx),
      .tx_sof        (tx_sof),
      .rx_sof        (rx_sof),
      .rx_err        (rx_err),
      .link_up       (link_up),
      .tx_frames     (tx_frames),
      .rx_frames     (rx_frames),
      .rx_errors     (rx_errors)
   );

endmodule

// File: test/xphy_chk.sv
//////////////////////////////////////////////////////////////
// assertions for one XGMII register stage, bound to both
// the tx and the rx stage below
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xphy_chk
(
   input logic                              clk156,
   input logic                              reset,
   input logic                              core_reset,
   input logic [xphy_pkg::XGMII_DATA_W-1:0] data,
   input logic [xphy_pkg::XGMII_CTRL_W-1:0] ctrl,
   input logic                              sof,
   input logic                              err
);

   // a word taken during core reset comes out as all idle control
   a_idle_in_reset : assert property (@(posedge clk156) disable iff (reset)
      core_reset |=> (data == {xphy_pkg::XGMII_LANES{xphy_pkg::XGMII_IDLE}}) && (ctrl == '1))
      else $error("stage output not idle during core reset");

   // no start or error strobe leaves the stage in core reset
   a_quiet_in_reset : assert property (@(posedge clk156) disable iff (reset)
      core_reset |=> !sof && !err)
      else $error("strobe seen during core reset");

endmodule

bind xgmii_tx_stage xphy_chk u_tx_chk
(
   .clk156     (clk156),
   .reset      (reset),
   .core_reset (core_reset_tx),
   .data       (xgmii_txd_int),
   .ctrl       (xgmii_txc_int),
   .sof        (tx_sof),
   .err        (1'b0)
);

bind xgmii_rx_stage xphy_chk u_rx_chk
(
   .clk156     (clk156),
   .reset      (reset),
   .core_reset (core_reset_rx),
   .data       (xgmii_rxd),
   .ctrl       (xgmii_rxc),
   .sof        (rx_sof),
   .err        (rx_err)
);

// File: test/xphy_tb.sv
//////////////////////////////////////////////////////////////
// testbench for the clk156 PHY interface top level
// drives one pattern line per cycle from the pattern file and
// compares every output against a cycle model each negedge
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module xphy_tb;

   localparam int          MAX_LINES  = 64;
   localparam logic [63:0] IDLE_WORD  = 64'h0707070707070707;
   localparam logic [7:0]  START_CHAR = 8'hFB;
   localparam logic [7:0]  ERROR_CHAR = 8'hFE;

   logic        clk156, reset;
   logic        tx_resetdone, rx_resetdone, tx_fault, signal_detect;
   logic [63:0] xgmii_txd, xgmii_rxd_int, xgmii_txd_int, xgmii_rxd;
   logic [7:0]  xgmii_txc, xgmii_rxc_int, xgmii_txc_int, xgmii_rxc;
   logic        resetdone, link_up;
   logic [15:0] tx_frames, rx_frames, rx_errors;

   // flags, txc, txd, rxc, rxd per line; flags bit 7 marks the end line
   logic [151:0] patterns [0:MAX_LINES-1];
   int           n_pat;
   int           limit = 0;
   int           cycles = 0;
   int           errors = 0;

   // reference model state
   logic [1:0]  m_sync_tx, m_sync_rx;
   logic [63:0] m_txd, m_rxd;
   logic [7:0]  m_txc, m_rxc;
   logic        m_tx_sof, m_rx_sof, m_rx_err, m_link;
   logic [15:0] m_tx_frames, m_rx_frames, m_rx_errors;

   xphy_top DUT (.*);

   always #4 clk156 = ~clk156;

   // start only in lane 0 with control set
   function automatic logic is_start(input logic [63:0] word, input logic [7:0] ctrl);
      return ctrl[0] && (word[7:0] == START_CHAR);
   endfunction

   // any control lane carrying the error character
   function automatic logic has_error(input logic [63:0] word, input logic [7:0] ctrl);
      logic hit;
      hit = 1'b0;
      for (int lane = 0; lane < 8; lane++)
         if (ctrl[lane] && (word[lane*8 +: 8] == ERROR_CHAR))
            hit = 1'b1;
      return hit;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         errors++;
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic apply_line(input logic [151:0] line);
      tx_resetdone  = line[147];
      rx_resetdone  = line[146];
      tx_fault      = line[145];
      signal_detect = line[144];
      xgmii_txc     = line[143:136];
      xgmii_txd     = line[135:72];
      xgmii_rxc_int = line[71:64];
      xgmii_rxd_int = line[63:0];
   endtask

   // two-flop hold chain per direction, one register stage, counters one cycle later
   always @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         m_sync_tx <= 2'b11;
         m_sync_rx <= 2'b11;
         m_txd <= IDLE_WORD;
         m_rxd <= IDLE_WORD;
         m_txc <= 8'hFF;
         m_rxc <= 8'hFF;
         {m_tx_sof, m_rx_sof, m_rx_err, m_link} <= 4'b0000;
         {m_tx_frames, m_rx_frames, m_rx_errors} <= '0;
      end
      else
      begin
         m_sync_tx <= {m_sync_tx[0], !tx_resetdone || tx_fault || !signal_detect};
         m_sync_rx <= {m_sync_rx[0], !rx_resetdone || tx_fault || !signal_detect};
         m_txd <= m_sync_tx[1] ? IDLE_WORD : xgmii_txd;
         m_txc <= m_sync_tx[1] ? 8'hFF : xgmii_txc;
         m_rxd <= m_sync_rx[1] ? IDLE_WORD : xgmii_rxd_int;
         m_rxc <= m_sync_rx[1] ? 8'hFF : xgmii_rxc_int;
         m_tx_sof <= !m_sync_tx[1] && is_start(xgmii_txd, xgmii_txc);
         m_rx_sof <= !m_sync_rx[1] && is_start(xgmii_rxd_int, xgmii_rxc_int);
         m_rx_err <= !m_sync_rx[1] && has_error(xgmii_rxd_int, xgmii_rxc_int);
         // counts stay far below saturation in these patterns
         m_tx_frames <= m_tx_frames + 16'(m_tx_sof);
         m_rx_frames <= m_rx_frames + 16'(m_rx_sof);
         m_rx_errors <= m_rx_errors + 16'(m_rx_err);
         m_link <= !m_sync_tx[1] && !m_sync_rx[1];
      end
   end

   // outputs settle at posedge, inputs move at posedge plus 1 ns
   always @(negedge clk156)
   begin
      check_value("txd_int", m_txd, xgmii_txd_int);
      check_value("txc_int", 64'(m_txc), 64'(xgmii_txc_int));
      check_value("rxd", m_rxd, xgmii_rxd);
      check_value("rxc", 64'(m_rxc), 64'(xgmii_rxc));
      check_value("link_up", 64'(m_link), 64'(link_up));
      check_value("resetdone", 64'(tx_resetdone && rx_resetdone), 64'(resetdone));
      check_value("tx_frames", 64'(m_tx_frames), 64'(tx_frames));
      check_value("rx_frames", 64'(m_rx_frames), 64'(rx_frames));
      check_value("rx_errors", 64'(m_rx_errors), 64'(rx_errors));
   end

   always @(posedge clk156)
   begin
      cycles++;
      if (limit > 0 && cycles >= limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("Test failed");
         $finish;
      end
   end

   initial
   begin
      clk156 = 1'b0;
      reset = 1'b1;
      apply_line({8'h00, 8'hFF, IDLE_WORD, 8'hFF, IDLE_WORD});
      n_pat = -1;
      $readmemh("test/xphy_patterns.txt", patterns);
      for (int i = 0; i < MAX_LINES; i++)
         if (n_pat < 0 && patterns[i][151] === 1'b1)
            n_pat = i;
      if (n_pat < 0)
      begin
         $display("pattern file has no end line with the expected counters");
         errors++;
         n_pat = 0;
      end
      limit = n_pat + 20;
      repeat (10) @(posedge clk156);
      #1;
      reset = 1'b0;
      for (int i = 0; i < n_pat; i++)
      begin
         apply_line(patterns[i]);
         @(posedge clk156);
         #1;
      end
      // last word through the stage, then into the counters
      repeat (3) @(posedge clk156);
      @(negedge clk156);
      check_value("final tx_frames", 64'(patterns[n_pat][47:32]), 64'(tx_frames));
      check_value("final rx_frames", 64'(patterns[n_pat][31:16]), 64'(rx_frames));
      check_value("final rx_errors", 64'(patterns[n_pat][15:0]), 64'(rx_errors));
      $display("%0d patterns run, %0d errors", n_pat, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: test/xphy_patterns.txt
// flags_txc_txd_rxc_rxd, flags bits 3..0 = tx_resetdone rx_resetdone tx_fault signal_detect
// end line has flags 80 and tx_frames rx_frames rx_errors in the low 48 bits
00_01_D5555555555555FB_08_11223344FE556677
0D_FF_0707070707070707_FF_0707070707070707
0D_FF_0707070707070707_FF_0707070707070707
0D_01_D5555555555555FB_01_D5555555555555FB
0D_00_0123456789ABCDEF_08_11223344FE556677
0D_F0_070707FD89ABCDEF_00_00000000000000FE
0D_01_D5555555555555FB_01_D5555555555555FB
0D_00_FEDCBA9876543210_FF_FEFEFEFEFEFEFEFE
0C_01_D5555555555555FB_01_D5555555555555FB
0C_01_D5555555555555FB_01_D5555555555555FB
0C_01_D5555555555555FB_01_D5555555555555FB
0D_FF_0707070707070707_FF_0707070707070707
0D_FF_0707070707070707_FF_0707070707070707
0D_01_D5555555555555FB_01_D5555555555555FB
0F_00_A5A5A5A5A5A5A5A5_FF_0707070707070707
0F_01_D5555555555555FB_01_D5555555555555FB
0F_01_D5555555555555FB_80_FE07070707070707
0D_FF_0707070707070707_FF_0707070707070707
80_00_0000000000000000_00_0000000600060002

// File: tb.f
logic/xphy_pkg.sv
logic/xphy_reset_sync.sv
logic/xgmii_tx_stage.sv
logic/xgmii_rx_stage.sv
logic/xphy_link_status.sv
logic/xphy_top.sv
test/xphy_chk.sv
test/xphy_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= xphy_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
